// File: Makefile
TOP = spi_bridge_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/spi_bridge_checker.sv
// concurrent checks on the bridge pins and response link that the testbench binds into the top level
module spi_bridge_checker import spi_bridge_pkg::*; (
	input lb_clk,
	input rst_n_i,
	input [NUM_DEV-1:0] ssb_i,
	input sclk_i,
	input mosi_i,
	input [7:0] resp_data_i,
	input resp_valid_i,
	input resp_ready_i
);

	// never two chips selected at once
	cs_exclusive: assert property (@(posedge lb_clk) disable iff (!rst_n_i) $onehot0(~ssb_i))
		else $error("more than one chip select active");

	resp_stable: assert property (@(posedge lb_clk) disable iff (!rst_n_i)
		resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_data_i))
		else $error("response byte dropped or changed before it was accepted");

	// clock and data low while no chip is selected
	spi_idle: assert property (@(posedge lb_clk) disable iff (!rst_n_i)
		&ssb_i |-> !sclk_i && !mosi_i)
		else $error("sclk or mosi not at idle level with no chip selected");

endmodule

// File: dv/spi_bridge_input.txt
// columns: command word, expected status, expected readback; all hex, one command per line
// command word: opcode, device, address, data (spi) or opcode, reserved, value (divider)
10031234 00 0000
1105beef 00 0000
20030000 00 1234
21050000 00 beef
1100a55a 00 0000
100f0f0f 00 0000
30000003 00 0000
21000000 00 a55a
200f0000 00 0f0f
0003dead 01 0000
7fffffff 01 0000
12011111 02 0000
22010000 02 0000
2f000000 02 0000
30000000 00 0000
10077e81 00 0000
20070000 00 7e81
11000001 00 0000
2105ffff 00 beef
21000000 00 0001
3fff0002 00 0000
20030000 00 1234
f0000000 01 0000
30000001 00 0000
200f0000 00 0f0f

// File: dv/spi_bridge_tb.sv
// testbench that plays the command vectors of the input file against a two-chip spi model
module spi_bridge_tb import spi_bridge_pkg::*; ();

	localparam int MAX_CMDS = 64;
	localparam int WAIT_LIMIT = 4000;

	logic lb_clk = 1'b0;
	logic rst_n_i;
	logic [7:0] host_data_i;
	logic host_valid_i;
	logic resp_ready_i;
	logic miso_i = 1'b0;
	wire host_ready_o, resp_valid_o, sclk_o, mosi_o;
	wire [7:0] resp_data_o;
	wire [NUM_DEV-1:0] ssb_o;

	logic [31:0] vec_mem [0:3*MAX_CMDS-1];
	int num_cmds;

	// spi device model with one 16-register store per chip select
	logic [15:0] dev_mem [0:31];
	logic [23:0] rx_sh;
	logic [15:0] tx_sh;
	logic tx_read, prev_sclk, was_sel;
	int rx_cnt, sel_dev, phase_len, phase_ref, fill_idx;
	logic [23:0] frame_q [$];
	int fdev_q [$];
	int fhalf_q [$];

	always #4 lb_clk = ~lb_clk;

	spi_bridge_top spi_bridge_top_inst (
		.lb_clk(lb_clk),
		.rst_n_i(rst_n_i),
		.host_data_i(host_data_i),
		.host_valid_i(host_valid_i),
		.host_ready_o(host_ready_o),
		.resp_data_o(resp_data_o),
		.resp_valid_o(resp_valid_o),
		.resp_ready_i(resp_ready_i),
		.ssb_o(ssb_o),
		.sclk_o(sclk_o),
		.mosi_o(mosi_o),
		.miso_i(miso_i)
	);

	bind spi_bridge_top spi_bridge_checker spi_bridge_checker_inst (
		.lb_clk(lb_clk),
		.rst_n_i(rst_n_i),
		.ssb_i(ssb_o),
		.sclk_i(sclk_o),
		.mosi_i(mosi_o),
		.resp_data_i(resp_data_o),
		.resp_valid_i(resp_valid_o),
		.resp_ready_i(resp_ready_i)
	);

	task end_with_failure();
		$display("tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task report_timeout(input string what);
		$display("ERROR %0t: timed out waiting for %s", $time, what);
		end_with_failure();
	endtask

	task check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
			end_with_failure();
		end
	endtask

	task close_phase();
		if (phase_ref == 0)
			phase_ref = phase_len;
		else
			check_eq(phase_len, phase_ref, "sclk phase length within a frame");
		phase_len = 1;
	endtask

	task load_vectors();
		for (int i = 0; i < 3*MAX_CMDS; i++)
			vec_mem[i] = {16'hffff, 16'(i)};
		$readmemh("dv/spi_bridge_input.txt", vec_mem);
		num_cmds = 0;
		while (num_cmds < MAX_CMDS && vec_mem[3*num_cmds+1][31:16] != 16'hffff)
			num_cmds++;
	endtask

	task send_commands();
		logic [31:0] word;
		int tries;
		for (int k = 0; k < num_cmds; k++) begin
			word = vec_mem[3*k];
			for (int b = CMD_BYTES - 1; b >= 0; b--) begin
				// now and then an idle cycle between bytes
				if ($urandom % 4 == 0) begin
					host_valid_i = 1'b0;
					@(negedge lb_clk);
				end
				host_valid_i = 1'b1;
				host_data_i = word[8*b +: 8];
				tries = 0;
				while (!host_ready_o) begin
					@(negedge lb_clk);
					tries++;
					if (tries > WAIT_LIMIT)
						report_timeout("host_ready_o");
				end
				@(negedge lb_clk);
			end
		end
		host_valid_i = 1'b0;
	endtask

	task recv_byte(output logic [7:0] b);
		int tries;
		logic taken;
		tries = 0;
		taken = 1'b0;
		while (!taken) begin
			resp_ready_i = ($urandom % 3 != 0);
			if (resp_valid_o && resp_ready_i) begin
				b = resp_data_o;
				taken = 1'b1;
			end
			@(negedge lb_clk);
			tries++;
			if (tries > WAIT_LIMIT)
				report_timeout("resp_valid_o");
		end
	endtask

	task collect_responses();
		logic [31:0] word;
		logic [7:0] stat, hi, lo;
		logic [3:0] op;
		int exp_half;
		exp_half = int'(DIV_RESET) + 1;
		for (int k = 0; k < num_cmds; k++) begin
			word = vec_mem[3*k];
			op = word[31:28];
			recv_byte(stat);
			recv_byte(hi);
			recv_byte(lo);
			check_eq(32'(stat), vec_mem[3*k+1], $sformatf("cmd %0d status", k));
			check_eq(32'({hi, lo}), vec_mem[3*k+2], $sformatf("cmd %0d readback", k));
			if (vec_mem[3*k+1] == 32'(STAT_OK) && (op == OP_SPI_WRITE || op == OP_SPI_READ)) begin
				if (frame_q.size() == 0) begin
					$display("ERROR %0t: no spi frame seen for command %0d", $time, k);
					end_with_failure();
				end
				check_eq(32'(frame_q.pop_front()),
					32'({op == OP_SPI_READ, word[22:16], word[15:0]}),
					$sformatf("cmd %0d spi frame", k));
				check_eq(fdev_q.pop_front(), 32'(word[27:24]), $sformatf("cmd %0d device", k));
				check_eq(fhalf_q.pop_front(), exp_half, $sformatf("cmd %0d sclk half period", k));
			end else if (vec_mem[3*k+1] == 32'(STAT_OK) && op == OP_SET_DIV) begin
				exp_half = int'(word[15:0]) + 1;
			end
		end
		resp_ready_i = 1'b0;
	endtask

	// mode 0 device samples mosi on rising sclk and shifts miso out on falling sclk
	always @(negedge lb_clk) begin
		if (!rst_n_i) begin
			was_sel = 1'b0;
			miso_i = 1'b0;
			for (fill_idx = 0; fill_idx < 32; fill_idx++)
				dev_mem[fill_idx] = 16'ha500 | 16'(fill_idx);
		end else if (ssb_o != '1) begin
			if (!was_sel) begin
				was_sel = 1'b1;
				sel_dev = ssb_o[0] ? 1 : 0;
				rx_cnt = 0;
				phase_len = 1;
				phase_ref = 0;
				tx_read = 1'b0;
			end else if (sclk_o == prev_sclk) begin
				phase_len++;
			end else begin
				close_phase();
				if (sclk_o) begin
					rx_sh = {rx_sh[22:0], mosi_o};
					rx_cnt++;
					// r/w bit and address known after the header
					if (rx_cnt == 8) begin
						tx_read = rx_sh[7];
						tx_sh = dev_mem[{sel_dev[0], rx_sh[3:0]}];
					end
				end else if (rx_cnt >= 8) begin
					miso_i = tx_read & tx_sh[15];
					tx_sh = {tx_sh[14:0], 1'b0};
				end
			end
		end else if (was_sel) begin
			// last high phase ends with the chip select
			was_sel = 1'b0;
			close_phase();
			check_eq(rx_cnt, FRAME_BITS, "spi frame bit count");
			if (!rx_sh[23])
				dev_mem[{sel_dev[0], rx_sh[19:16]}] = rx_sh[15:0];
			miso_i = 1'b0;
			frame_q.push_back(rx_sh);
			fdev_q.push_back(sel_dev);
			fhalf_q.push_back(phase_ref);
		end
		prev_sclk = sclk_o;
	end

	initial begin
		rst_n_i = 1'b0;
		host_valid_i = 1'b0;
		host_data_i = 8'h00;
		resp_ready_i = 1'b0;
		void'($urandom(32'h6efa92d5));
		load_vectors();
		if (num_cmds == 0) begin
			$display("ERROR: no command vectors read from the input file");
			end_with_failure();
		end
		repeat (5) @(posedge lb_clk);
		@(negedge lb_clk);
		rst_n_i = 1'b1;
		@(negedge lb_clk);
		check_eq(32'(resp_valid_o), 0, "resp_valid_o after reset");
		check_eq(32'(host_ready_o), 1, "host_ready_o after reset");
		check_eq(32'(&ssb_o), 1, "ssb_o after reset");
		check_eq(32'(sclk_o), 0, "sclk_o after reset");
		check_eq(32'(mosi_o), 0, "mosi_o after reset");
		fork
			send_commands();
			collect_responses();
		join
		if (frame_q.size() == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("ERROR: %0d spi frames without a matching command", frame_q.size());
			end_with_failure();
		end
	end

endmodule

// File: hdl/cmd_decode.sv
// assembles four host bytes into a command word, classifies it and holds it for the execute stage
module cmd_decode import spi_bridge_pkg::*; (
	input lb_clk,
	input rst_n_i,
	input [7:0] host_data_i,
	input host_valid_i,
	output host_ready_o,
	output dec_valid_o,
	input dec_ready_i,
	output cmd_kind_e dec_kind_o,
	output [3:0] dec_dev_o,
	output [7:0] dec_addr_o,
	output [15:0] dec_data_o,
	output [7:0] dec_status_o
);

	logic [1:0] byte_cnt;
	logic [8*(CMD_BYTES-1)-1:0] asm_q;
	logic host_fire, word_done;
	cmd_word_u word;
	cmd_kind_e kind_d;
	logic [7:0] status_d;

	logic hold_valid;
	cmd_kind_e hold_kind;
	logic [3:0] hold_dev;
	logic [7:0] hold_addr;
	logic [15:0] hold_data;
	logic [7:0] hold_status;

	// accept bytes while the holding register is free or being drained
	assign host_ready_o = !hold_valid || dec_ready_i;
	assign host_fire = host_valid_i && host_ready_o;
	assign word_done = host_fire && (byte_cnt == 2'(CMD_BYTES - 1));

	always_comb begin
		word = {asm_q, host_data_i};
		kind_d = KIND_BAD;
		status_d = STAT_BAD_OP;
		case (word.spi.opcode)
			OP_SPI_WRITE, OP_SPI_READ: begin
				if (word.spi.dev >= 4'(NUM_DEV)) begin
					status_d = STAT_BAD_DEV;
				end else begin
					kind_d = (word.spi.opcode == OP_SPI_READ) ? KIND_READ : KIND_WRITE;
					status_d = STAT_OK;
				end
			end
			OP_SET_DIV: begin
				kind_d = KIND_DIV;
				status_d = STAT_OK;
			end
			default: ;
		endcase
	end

	always_ff @(posedge lb_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			byte_cnt <= '0;
			hold_valid <= 1'b0;
		end else begin
			if (host_fire)
				byte_cnt <= word_done ? 2'd0 : byte_cnt + 2'd1;
			if (word_done)
				hold_valid <= 1'b1;
			else if (dec_ready_i)
				hold_valid <= 1'b0;
		end
	end

	// assembly shift register and decoded command
	always_ff @(posedge lb_clk) begin
		if (host_fire)
			asm_q <= {asm_q[8*(CMD_BYTES-2)-1:0], host_data_i};
		if (word_done) begin
			hold_kind <= kind_d;
			hold_dev <= word.spi.dev;
			hold_addr <= word.spi.addr;
			hold_data <= word.spi.wdata;
			hold_status <= status_d;
		end
	end

	assign dec_valid_o = hold_valid;
	assign dec_kind_o = hold_kind;
	assign dec_dev_o = hold_dev;
	assign dec_addr_o = hold_addr;
	assign dec_data_o = hold_data;
	assign dec_status_o = hold_status;

endmodule

// File: hdl/rdbk_result.sv
// turns each execute result into a status byte and two readback bytes on the response link
module rdbk_result import spi_bridge_pkg::*; (
	input lb_clk,
	input rst_n_i,
	input exe_valid_i,
	output exe_ready_o,
	input [7:0] exe_status_i,
	input [15:0] exe_rdbk_i,
	output [7:0] resp_data_o,
	output resp_valid_o,
	input resp_ready_i
);

	logic [8*RESP_BYTES-1:0] resp_q;
	logic [1:0] byte_cnt;
	logic resp_valid_q;
	logic take, send, last;

	// busy from result capture until the last byte goes
	assign exe_ready_o = !resp_valid_q;
	assign take = exe_valid_i && exe_ready_o;
	assign send = resp_valid_q && resp_ready_i;
	assign last = (byte_cnt == 2'(RESP_BYTES - 1));

	always_ff @(posedge lb_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			resp_valid_q <= 1'b0;
			byte_cnt <= '0;
		end else begin
			if (take) begin
				resp_valid_q <= 1'b1;
				byte_cnt <= '0;
			end else if (send) begin
				if (last)
					resp_valid_q <= 1'b0;
				else
					byte_cnt <= byte_cnt + 2'd1;
			end
		end
	end

	// status first, then readback high and low byte
	always_ff @(posedge lb_clk) begin
		if (take)
			resp_q <= {exe_status_i, exe_rdbk_i};
		else if (send)
			resp_q <= {resp_q[8*(RESP_BYTES-1)-1:0], 8'h00};
	end

	assign resp_data_o = resp_q[8*RESP_BYTES-1 -: 8];
	assign resp_valid_o = resp_valid_q;

endmodule

// File: hdl/spi_bridge_pkg.sv
// shared command layout, opcodes, status codes and sizes that every bridge module imports
package spi_bridge_pkg;

	// host link framing
	localparam int CMD_BYTES = 4;
	localparam int RESP_BYTES = 3;

	localparam logic [3:0] OP_SPI_WRITE = 4'd1;
	localparam logic [3:0] OP_SPI_READ = 4'd2;
	localparam logic [3:0] OP_SET_DIV = 4'd3;

	localparam logic [7:0] STAT_OK = 8'h00;
	localparam logic [7:0] STAT_BAD_OP = 8'h01;
	localparam logic [7:0] STAT_BAD_DEV = 8'h02;

	// two chip selects, 24-bit frames of r/w, 7 address bits, 16 data bits
	localparam int NUM_DEV = 2;
	localparam int FRAME_BITS = 24;
	localparam logic [15:0] DIV_RESET = 16'd1;

	typedef enum logic [1:0] {
		KIND_WRITE,
		KIND_READ,
		KIND_DIV,
		KIND_BAD
	} cmd_kind_e;

	// one command word seen either as an spi access or as a local setting
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [3:0] dev;
			logic [7:0] addr;
			logic [15:0] wdata;
		} spi;
		struct packed {
			logic [3:0] opcode;
			logic [11:0] rsvd;
			logic [15:0] value;
		} cfg;
	} cmd_word_u;

endpackage

// File: hdl/spi_bridge_top.sv
// top level of the host to spi bridge that wires the decode, execute and result stages to the pins
module spi_bridge_top import spi_bridge_pkg::*; (
	input lb_clk,
	input rst_n_i,
	input [7:0] host_data_i,
	input host_valid_i,
	output host_ready_o,
	output [7:0] resp_data_o,
	output resp_valid_o,
	input resp_ready_i,
	output [NUM_DEV-1:0] ssb_o,
	output sclk_o,
	output mosi_o,
	input miso_i
);

	wire dec_valid, dec_ready;
	cmd_kind_e dec_kind;
	wire [3:0] dec_dev;
	wire [7:0] dec_addr;
	wire [15:0] dec_data;
	wire [7:0] dec_status;
	wire exe_valid, exe_ready;
	wire [7:0] exe_status;
	wire [15:0] exe_rdbk;

	cmd_decode cmd_decode_inst (
		.lb_clk(lb_clk),
		.rst_n_i(rst_n_i),
		.host_data_i(host_data_i),
		.host_valid_i(host_valid_i),
		.host_ready_o(host_ready_o),
		.dec_valid_o(dec_valid),
		.dec_ready_i(dec_ready),
		.dec_kind_o(dec_kind),
		.dec_dev_o(dec_dev),
		.dec_addr_o(dec_addr),
		.dec_data_o(dec_data),
		.dec_status_o(dec_status)
	);

	spi_execute spi_execute_inst (
		.lb_clk(lb_clk),
		.rst_n_i(rst_n_i),
		.dec_valid_i(dec_valid),
		.dec_ready_o(dec_ready),
		.dec_kind_i(dec_kind),
		.dec_dev_i(dec_dev),
		.dec_addr_i(dec_addr),
		.dec_data_i(dec_data),
		.dec_status_i(dec_status),
		.exe_valid_o(exe_valid),
		.exe_ready_i(exe_ready),
		.exe_status_o(exe_status),
		.exe_rdbk_o(exe_rdbk),
		.ssb_o(ssb_o),
		.sclk_o(sclk_o),
		.mosi_o(mosi_o),
		.miso_i(miso_i)
	);

	rdbk_result rdbk_result_inst (
		.lb_clk(lb_clk),
		.rst_n_i(rst_n_i),
		.exe_valid_i(exe_valid),
		.exe_ready_o(exe_ready),
		.exe_status_i(exe_status),
		.exe_rdbk_i(exe_rdbk),
		.resp_data_o(resp_data_o),
		.resp_valid_o(resp_valid_o),
		.resp_ready_i(resp_ready_i)
	);

endmodule

// File: hdl/spi_execute.sv
// runs one spi frame per decoded command, or loads the local clock divider, and hands a result on
module spi_execute import spi_bridge_pkg::*; (
	input lb_clk,
	input rst_n_i,
	input dec_valid_i,
	output dec_ready_o,
	input cmd_kind_e dec_kind_i,
	input [3:0] dec_dev_i,
	input [7:0] dec_addr_i,
	input [15:0] dec_data_i,
	input [7:0] dec_status_i,
	output exe_valid_o,
	input exe_ready_i,
	output [7:0] exe_status_o,
	output [15:0] exe_rdbk_o,
	output [NUM_DEV-1:0] ssb_o,
	output sclk_o,
	output mosi_o,
	input miso_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_FINISH,
		ST_HOLD
	} state_e;

	state_e state;
	logic [15:0] div_q;
	logic [15:0] div_cnt;
	logic [4:0] bit_cnt;
	logic [FRAME_BITS-1:0] shift_q;
	logic [15:0] rx_q;
	logic [15:0] rdbk_q;
	logic [7:0] status_q;
	logic is_read_q;
	logic [NUM_DEV-1:0] ssb_q;
	logic sclk_q, mosi_q;
	logic accept, half_done;
	logic [FRAME_BITS-1:0] frame;

	assign dec_ready_o = (state == ST_IDLE);
	assign accept = dec_valid_i && dec_ready_o;
	assign half_done = (div_cnt == div_q);
	// read bit set for reads, then 7 address bits and the data word
	assign frame = {dec_kind_i == KIND_READ, dec_addr_i[6:0], dec_data_i};

	always_ff @(posedge lb_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= ST_IDLE;
			div_q <= DIV_RESET;
			div_cnt <= '0;
			bit_cnt <= '0;
			ssb_q <= '1;
			sclk_q <= 1'b0;
			mosi_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (accept) begin
					div_cnt <= '0;
					bit_cnt <= '0;
					if (dec_kind_i == KIND_READ || dec_kind_i == KIND_WRITE) begin
						ssb_q <= ~(NUM_DEV'(1) << dec_dev_i);
						mosi_q <= frame[FRAME_BITS-1];
						state <= ST_SHIFT;
					end else begin
						if (dec_kind_i == KIND_DIV)
							div_q <= dec_data_i;
						state <= ST_HOLD;
					end
				end
				ST_SHIFT: begin
					div_cnt <= half_done ? 16'd0 : div_cnt + 16'd1;
					if (half_done && !sclk_q) begin
						sclk_q <= 1'b1;
						bit_cnt <= bit_cnt + 5'd1;
					end else if (half_done) begin
						sclk_q <= 1'b0;
						if (bit_cnt == 5'(FRAME_BITS)) begin
							// last falling edge closes the frame
							ssb_q <= '1;
							mosi_q <= 1'b0;
							state <= ST_FINISH;
						end else begin
							mosi_q <= shift_q[FRAME_BITS-1];
						end
					end
				end
				ST_FINISH: state <= ST_HOLD;
				ST_HOLD: if (exe_ready_i) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge lb_clk) begin
		if (accept) begin
			shift_q <= {frame[FRAME_BITS-2:0], 1'b0};
			status_q <= dec_status_i;
			is_read_q <= (dec_kind_i == KIND_READ);
			rdbk_q <= '0;
		end
		if (state == ST_SHIFT && half_done) begin
			// sample miso on the rising edge, advance mosi data on the falling one
			if (!sclk_q)
				rx_q <= {rx_q[14:0], miso_i};
			else
				shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
		end
		if (state == ST_FINISH && is_read_q)
			rdbk_q <= rx_q;
	end

	assign exe_valid_o = (state == ST_HOLD);
	assign exe_status_o = status_q;
	assign exe_rdbk_o = rdbk_q;
	assign ssb_o = ssb_q;
	assign sclk_o = sclk_q;
	assign mosi_o = mosi_q;

endmodule

// File: src.f
hdl/spi_bridge_pkg.sv
hdl/cmd_decode.sv
hdl/spi_execute.sv
hdl/rdbk_result.sv
hdl/spi_bridge_top.sv
dv/spi_bridge_checker.sv
dv/spi_bridge_tb.sv
